// File: source/udp_rx_params.svh
// ------------------------------
// udp receive stage parameters
// widths and header sizes shared by the parser blocks
// ------------------------------

`ifndef UDP_RX_PARAMS_SVH
`define UDP_RX_PARAMS_SVH

// one payload byte on the stream
`define UDP_DATA_W 8

// fixed udp header, ports + length + checksum
`define UDP_HDR_BYTES 8

// index into the header bytes
`define UDP_HDR_PTR_W 3

`endif

// File: source/udp_rx_pkg.sv
// ------------------------------
// udp receive stage types
// field types and parser state encoding
// ------------------------------
`default_nettype none

`include "udp_rx_params.svh"

package udp_rx_pkg;

    typedef logic [`UDP_DATA_W-1:0] data_t;

    // ports, length and checksum are all 16 bit
    typedef logic [15:0] port_t;

    typedef logic [31:0] ip_addr_t;

    typedef logic [`UDP_HDR_PTR_W-1:0] hdr_ptr_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_READ_HEADER,
        ST_READ_PAYLOAD,
        ST_READ_PAYLOAD_LAST
    } rx_state_t;

endpackage

`default_nettype wire

// File: source/udp_hdr_regs.sv
// ------------------------------
// udp header registers
// latch ip fields, assemble udp header big-endian
// ------------------------------
`timescale 1ns/10ps
`default_nettype none

module udp_hdr_regs (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    ip_hdr_store,
    input  udp_rx_pkg::data_t      s_ip_protocol,
    input  udp_rx_pkg::ip_addr_t   s_ip_source_ip,
    input  udp_rx_pkg::ip_addr_t   s_ip_dest_ip,
    input  wire                    hdr_byte_en,
    input  udp_rx_pkg::hdr_ptr_t   hdr_ptr,
    input  udp_rx_pkg::data_t      tdata,
    output udp_rx_pkg::data_t      m_ip_protocol,
    output udp_rx_pkg::ip_addr_t   m_ip_source_ip,
    output udp_rx_pkg::ip_addr_t   m_ip_dest_ip,
    output udp_rx_pkg::port_t      m_udp_source_port,
    output udp_rx_pkg::port_t      m_udp_dest_port,
    output udp_rx_pkg::port_t      m_udp_length,
    output udp_rx_pkg::port_t      m_udp_checksum
);

    // ip fields taken once per frame
    always_ff @(posedge clk) begin
        if (ip_hdr_store) begin
            m_ip_protocol  <= s_ip_protocol;
            m_ip_source_ip <= s_ip_source_ip;
            m_ip_dest_ip   <= s_ip_dest_ip;
        end
    end

    // even pointer is the high byte, network order
    always_ff @(posedge clk) begin
        if (hdr_byte_en) begin
            case (hdr_ptr)
                3'd0: m_udp_source_port[15:8] <= tdata;
                3'd1: m_udp_source_port[7:0]  <= tdata;
                3'd2: m_udp_dest_port[15:8]   <= tdata;
                3'd3: m_udp_dest_port[7:0]    <= tdata;
                3'd4: m_udp_length[15:8]      <= tdata;
                3'd5: m_udp_length[7:0]       <= tdata;
                3'd6: m_udp_checksum[15:8]    <= tdata;
                default: m_udp_checksum[7:0]  <= tdata;
            endcase
        end
    end

    // parser only stores the ip header while idle
    a_store_exclusive: assert property (
        @(posedge clk) disable iff (rst) !(hdr_byte_en && ip_hdr_store)
    ) else $error("header byte strobe during ip header store");

endmodule

`default_nettype wire

// File: source/udp_rx_fsm.sv
// ------------------------------
// udp frame parser
// strips the udp header, forwards and trims payload
// flags early frame ends
// ------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "udp_rx_params.svh"

module udp_rx_fsm (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    s_ip_hdr_valid,
    output logic                   s_ip_hdr_ready,
    input  udp_rx_pkg::data_t      s_ip_payload_tdata,
    input  wire                    s_ip_payload_tvalid,
    output logic                   s_ip_payload_tready,
    input  wire                    s_ip_payload_tlast,
    input  wire                    s_ip_payload_tuser,
    output logic                   m_udp_hdr_valid,
    input  wire                    m_udp_hdr_ready,
    output logic                   ip_hdr_store,
    output logic                   hdr_byte_en,
    output udp_rx_pkg::hdr_ptr_t   hdr_ptr,
    input  udp_rx_pkg::port_t      udp_length,
    output udp_rx_pkg::data_t      int_tdata,
    output logic                   int_tvalid,
    output logic                   int_tlast,
    output logic                   int_tuser,
    input  wire                    int_tready_early,
    output logic                   error_header_early_termination,
    output logic                   error_payload_early_termination
);

    udp_rx_pkg::rx_state_t state, state_next;
    udp_rx_pkg::hdr_ptr_t  hdr_ptr_next;
    udp_rx_pkg::port_t     word_count, word_count_next;
    udp_rx_pkg::data_t     last_byte;

    logic hdr_ready_next;
    logic payload_tready_next;
    logic hdr_valid_next;
    logic err_hdr_next;
    logic err_payload_next;
    logic store_last;
    logic in_xfer;

    assign in_xfer = s_ip_payload_tready && s_ip_payload_tvalid;

    always_comb begin
        state_next          = state;
        hdr_ready_next      = 1'b0;
        payload_tready_next = 1'b0;
        hdr_valid_next      = m_udp_hdr_valid && !m_udp_hdr_ready;
        hdr_ptr_next        = hdr_ptr;
        word_count_next     = word_count;
        err_hdr_next        = 1'b0;
        err_payload_next    = 1'b0;
        ip_hdr_store        = 1'b0;
        hdr_byte_en         = 1'b0;
        store_last          = 1'b0;
        int_tdata           = s_ip_payload_tdata;
        int_tvalid          = 1'b0;
        int_tlast           = s_ip_payload_tlast;
        int_tuser           = s_ip_payload_tuser;

        case (state)
            udp_rx_pkg::ST_IDLE: begin
                hdr_ptr_next   = '0;
                // hold off the next frame until the pending header leaves
                hdr_ready_next = !hdr_valid_next;
                if (s_ip_hdr_ready && s_ip_hdr_valid) begin
                    hdr_ready_next      = 1'b0;
                    payload_tready_next = 1'b1;
                    ip_hdr_store        = 1'b1;
                    state_next          = udp_rx_pkg::ST_READ_HEADER;
                end
            end
            udp_rx_pkg::ST_READ_HEADER: begin
                payload_tready_next = 1'b1;
                word_count_next = udp_length - udp_rx_pkg::port_t'(`UDP_HDR_BYTES);
                if (in_xfer) begin
                    hdr_byte_en  = 1'b1;
                    hdr_ptr_next = hdr_ptr + 1'b1;
                    if (hdr_ptr == udp_rx_pkg::hdr_ptr_t'(`UDP_HDR_BYTES - 1)) begin
                        hdr_valid_next      = 1'b1;
                        payload_tready_next = int_tready_early;
                        state_next          = udp_rx_pkg::ST_READ_PAYLOAD;
                    end
                    if (s_ip_payload_tlast) begin
                        // frame ended inside the udp header
                        err_hdr_next        = 1'b1;
                        hdr_valid_next      = 1'b0;
                        hdr_ready_next      = !hdr_valid_next;
                        payload_tready_next = 1'b0;
                        state_next          = udp_rx_pkg::ST_IDLE;
                    end
                end
            end
            udp_rx_pkg::ST_READ_PAYLOAD: begin
                payload_tready_next = int_tready_early;
                if (in_xfer) begin
                    word_count_next = word_count - 16'd1;
                    int_tvalid      = 1'b1;
                    if (s_ip_payload_tlast) begin
                        if (word_count != 16'd1) begin
                            // short payload
                            int_tuser        = 1'b1;
                            err_payload_next = 1'b1;
                        end
                        hdr_ready_next      = !hdr_valid_next;
                        payload_tready_next = 1'b0;
                        state_next          = udp_rx_pkg::ST_IDLE;
                    end else if (word_count == 16'd1) begin
                        // keep the final byte until the frame ends
                        store_last = 1'b1;
                        int_tvalid = 1'b0;
                        state_next = udp_rx_pkg::ST_READ_PAYLOAD_LAST;
                    end
                end
            end
            udp_rx_pkg::ST_READ_PAYLOAD_LAST: begin
                // padding is read and dropped
                payload_tready_next = int_tready_early;
                int_tdata = last_byte;
                if (in_xfer && s_ip_payload_tlast) begin
                    hdr_ready_next      = !hdr_valid_next;
                    payload_tready_next = 1'b0;
                    int_tvalid          = 1'b1;
                    state_next          = udp_rx_pkg::ST_IDLE;
                end
            end
            default: state_next = udp_rx_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state                           <= udp_rx_pkg::ST_IDLE;
            s_ip_hdr_ready                  <= 1'b0;
            s_ip_payload_tready             <= 1'b0;
            m_udp_hdr_valid                 <= 1'b0;
            hdr_ptr                         <= '0;
            error_header_early_termination  <= 1'b0;
            error_payload_early_termination <= 1'b0;
        end else begin
            state                           <= state_next;
            s_ip_hdr_ready                  <= hdr_ready_next;
            s_ip_payload_tready             <= payload_tready_next;
            m_udp_hdr_valid                 <= hdr_valid_next;
            hdr_ptr                         <= hdr_ptr_next;
            error_header_early_termination  <= err_hdr_next;
            error_payload_early_termination <= err_payload_next;
        end
    end

    always_ff @(posedge clk) begin
        word_count <= word_count_next;
        if (store_last) begin
            last_byte <= s_ip_payload_tdata;
        end
    end

    a_err_hdr_pulse: assert property (
        @(posedge clk) disable iff (rst)
        error_header_early_termination |=> !error_header_early_termination
    ) else $error("header error longer than one cycle");

    a_err_payload_pulse: assert property (
        @(posedge clk) disable iff (rst)
        error_payload_early_termination |=> !error_payload_early_termination
    ) else $error("payload error longer than one cycle");

    a_hdr_valid_hold: assert property (
        @(posedge clk) disable iff (rst)
        m_udp_hdr_valid && !m_udp_hdr_ready |=> m_udp_hdr_valid
    ) else $error("udp header valid dropped without ready");

endmodule

`default_nettype wire

// File: source/axis_skid_buf.sv
// ------------------------------
// two entry skid buffer
// registered output slice for the payload stream
// ------------------------------
`timescale 1ns/10ps
`default_nettype none

module axis_skid_buf (
    input  wire                 clk,
    input  wire                 rst,
    input  udp_rx_pkg::data_t   int_tdata,
    input  wire                 int_tvalid,
    input  wire                 int_tlast,
    input  wire                 int_tuser,
    output logic                int_tready_early,
    output udp_rx_pkg::data_t   m_tdata,
    output logic                m_tvalid,
    input  wire                 m_tready,
    output logic                m_tlast,
    output logic                m_tuser
);

    udp_rx_pkg::data_t temp_tdata;
    logic temp_tvalid, temp_tlast, temp_tuser;
    logic int_tready_reg;
    logic m_tvalid_next, temp_tvalid_next;
    logic int_to_out, int_to_temp, temp_to_out;

    // accept next cycle if output drains or both slots are empty
    assign int_tready_early = m_tready || (!temp_tvalid && !m_tvalid);

    always_comb begin
        m_tvalid_next    = m_tvalid;
        temp_tvalid_next = temp_tvalid;
        int_to_out       = 1'b0;
        int_to_temp      = 1'b0;
        temp_to_out      = 1'b0;

        if (int_tready_reg) begin
            if (m_tready || !m_tvalid) begin
                m_tvalid_next = int_tvalid;
                int_to_out    = 1'b1;
            end else begin
                // output stalled, park the byte
                temp_tvalid_next = int_tvalid;
                int_to_temp      = 1'b1;
            end
        end else if (m_tready) begin
            m_tvalid_next    = temp_tvalid;
            temp_tvalid_next = 1'b0;
            temp_to_out      = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            m_tvalid       <= 1'b0;
            temp_tvalid    <= 1'b0;
            int_tready_reg <= 1'b0;
        end else begin
            m_tvalid       <= m_tvalid_next;
            temp_tvalid    <= temp_tvalid_next;
            int_tready_reg <= int_tready_early;
        end
    end

    always_ff @(posedge clk) begin
        if (int_to_out) begin
            m_tdata <= int_tdata;
            m_tlast <= int_tlast;
            m_tuser <= int_tuser;
        end else if (temp_to_out) begin
            m_tdata <= temp_tdata;
            m_tlast <= temp_tlast;
            m_tuser <= temp_tuser;
        end
        if (int_to_temp) begin
            temp_tdata <= int_tdata;
            temp_tlast <= int_tlast;
            temp_tuser <= int_tuser;
        end
    end

    a_out_stable: assert property (
        @(posedge clk) disable iff (rst)
        m_tvalid && !m_tready |=>
            m_tvalid && $stable(m_tdata) && $stable(m_tlast) && $stable(m_tuser)
    ) else $error("output byte changed while stalled");

endmodule

`default_nettype wire

// File: source/udp_rx_top.sv
// ------------------------------
// udp receive stage
// ip frame in, udp header and payload out
// ------------------------------
`timescale 1ns/10ps
`default_nettype none

module udp_rx_top (
    input  wire                    clk,
    input  wire                    rst,

    // ip frame in
    input  wire                    s_ip_hdr_valid,
    output logic                   s_ip_hdr_ready,
    input  udp_rx_pkg::data_t      s_ip_protocol,
    input  udp_rx_pkg::ip_addr_t   s_ip_source_ip,
    input  udp_rx_pkg::ip_addr_t   s_ip_dest_ip,
    input  udp_rx_pkg::data_t      s_ip_payload_tdata,
    input  wire                    s_ip_payload_tvalid,
    output logic                   s_ip_payload_tready,
    input  wire                    s_ip_payload_tlast,
    input  wire                    s_ip_payload_tuser,

    // udp frame out
    output logic                   m_udp_hdr_valid,
    input  wire                    m_udp_hdr_ready,
    output udp_rx_pkg::data_t      m_ip_protocol,
    output udp_rx_pkg::ip_addr_t   m_ip_source_ip,
    output udp_rx_pkg::ip_addr_t   m_ip_dest_ip,
    output udp_rx_pkg::port_t      m_udp_source_port,
    output udp_rx_pkg::port_t      m_udp_dest_port,
    output udp_rx_pkg::port_t      m_udp_length,
    output udp_rx_pkg::port_t      m_udp_checksum,
    output udp_rx_pkg::data_t      m_udp_payload_tdata,
    output logic                   m_udp_payload_tvalid,
    input  wire                    m_udp_payload_tready,
    output logic                   m_udp_payload_tlast,
    output logic                   m_udp_payload_tuser,

    output logic                   error_header_early_termination,
    output logic                   error_payload_early_termination
);

    logic                 ip_hdr_store;
    logic                 hdr_byte_en;
    udp_rx_pkg::hdr_ptr_t hdr_ptr;
    udp_rx_pkg::data_t    int_tdata;
    logic                 int_tvalid;
    logic                 int_tlast;
    logic                 int_tuser;
    logic                 int_tready_early;

    udp_rx_fsm i_fsm (
        .clk                             (clk),
        .rst                             (rst),
        .s_ip_hdr_valid                  (s_ip_hdr_valid),
        .s_ip_hdr_ready                  (s_ip_hdr_ready),
        .s_ip_payload_tdata              (s_ip_payload_tdata),
        .s_ip_payload_tvalid             (s_ip_payload_tvalid),
        .s_ip_payload_tready             (s_ip_payload_tready),
        .s_ip_payload_tlast              (s_ip_payload_tlast),
        .s_ip_payload_tuser              (s_ip_payload_tuser),
        .m_udp_hdr_valid                 (m_udp_hdr_valid),
        .m_udp_hdr_ready                 (m_udp_hdr_ready),
        .ip_hdr_store                    (ip_hdr_store),
        .hdr_byte_en                     (hdr_byte_en),
        .hdr_ptr                         (hdr_ptr),
        .udp_length                      (m_udp_length),
        .int_tdata                       (int_tdata),
        .int_tvalid                      (int_tvalid),
        .int_tlast                       (int_tlast),
        .int_tuser                       (int_tuser),
        .int_tready_early                (int_tready_early),
        .error_header_early_termination  (error_header_early_termination),
        .error_payload_early_termination (error_payload_early_termination)
    );

    // header bytes are taken straight off the input stream
    udp_hdr_regs i_hdr_regs (
        .clk               (clk),
        .rst               (rst),
        .ip_hdr_store      (ip_hdr_store),
        .s_ip_protocol     (s_ip_protocol),
        .s_ip_source_ip    (s_ip_source_ip),
        .s_ip_dest_ip      (s_ip_dest_ip),
        .hdr_byte_en       (hdr_byte_en),
        .hdr_ptr           (hdr_ptr),
        .tdata             (s_ip_payload_tdata),
        .m_ip_protocol     (m_ip_protocol),
        .m_ip_source_ip    (m_ip_source_ip),
        .m_ip_dest_ip      (m_ip_dest_ip),
        .m_udp_source_port (m_udp_source_port),
        .m_udp_dest_port   (m_udp_dest_port),
        .m_udp_length      (m_udp_length),
        .m_udp_checksum    (m_udp_checksum)
    );

    axis_skid_buf i_skid (
        .clk              (clk),
        .rst              (rst),
        .int_tdata        (int_tdata),
        .int_tvalid       (int_tvalid),
        .int_tlast        (int_tlast),
        .int_tuser        (int_tuser),
        .int_tready_early (int_tready_early),
        .m_tdata          (m_udp_payload_tdata),
        .m_tvalid         (m_udp_payload_tvalid),
        .m_tready         (m_udp_payload_tready),
        .m_tlast          (m_udp_payload_tlast),
        .m_tuser          (m_udp_payload_tuser)
    );

endmodule

`default_nettype wire

// File: bench/udp_rx_tb.sv
// ------------------------------
// udp receive stage testbench
// random frames against expected header and byte queues
// ------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "udp_rx_params.svh"

module udp_rx_tb;

    localparam int N_FRAMES    = 60;
    localparam int MAX_PAYLOAD = 12;
    localparam int MAX_PAD     = 4;
    localparam int MAX_FRAME   = `UDP_HDR_BYTES + MAX_PAYLOAD + MAX_PAD;

    logic                 clk;
    logic                 rst;
    logic                 s_ip_hdr_valid;
    logic                 s_ip_hdr_ready;
    udp_rx_pkg::data_t    s_ip_protocol;
    udp_rx_pkg::ip_addr_t s_ip_source_ip;
    udp_rx_pkg::ip_addr_t s_ip_dest_ip;
    udp_rx_pkg::data_t    s_ip_payload_tdata;
    logic                 s_ip_payload_tvalid;
    logic                 s_ip_payload_tready;
    logic                 s_ip_payload_tlast;
    logic                 s_ip_payload_tuser;
    logic                 m_udp_hdr_valid;
    logic                 m_udp_hdr_ready;
    udp_rx_pkg::data_t    m_ip_protocol;
    udp_rx_pkg::ip_addr_t m_ip_source_ip;
    udp_rx_pkg::ip_addr_t m_ip_dest_ip;
    udp_rx_pkg::port_t    m_udp_source_port;
    udp_rx_pkg::port_t    m_udp_dest_port;
    udp_rx_pkg::port_t    m_udp_length;
    udp_rx_pkg::port_t    m_udp_checksum;
    udp_rx_pkg::data_t    m_udp_payload_tdata;
    logic                 m_udp_payload_tvalid;
    logic                 m_udp_payload_tready;
    logic                 m_udp_payload_tlast;
    logic                 m_udp_payload_tuser;
    logic                 error_header_early_termination;
    logic                 error_payload_early_termination;

    integer seed = 32'ha743;
    int     error_count = 0;
    int     hdr_err_exp = 0;
    int     pay_err_exp = 0;
    int     hdr_err_seen = 0;
    int     pay_err_seen = 0;

    // header word is {protocol, src, dst, sport, dport, length, checksum}
    logic [135:0] hdr_q[$];
    // payload entry is {user, last, data}
    logic [9:0]   pay_q[$];

    udp_rx_top i_dut (.*);

    always #5 clk = ~clk;

    task automatic report(input string msg);
        $display("** Error at %0d ns: %s", $time, msg);
        error_count++;
    endtask

    function automatic int pick(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    // random back-pressure on both outputs
    always @(posedge clk) begin
        m_udp_payload_tready <= (pick(4) != 0);
        m_udp_hdr_ready      <= (pick(3) != 0);
    end

    task automatic send_frame(input int kind);
        udp_rx_pkg::data_t    proto;
        udp_rx_pkg::ip_addr_t src;
        udp_rx_pkg::ip_addr_t dst;
        udp_rx_pkg::port_t    sport;
        udp_rx_pkg::port_t    dport;
        udp_rx_pkg::port_t    ulen;
        udp_rx_pkg::port_t    csum;
        udp_rx_pkg::data_t    bytes[$];
        int                   plen;
        int                   flen;
        int                   nout;
        proto = pick(256);
        src   = $random(seed);
        dst   = $random(seed);
        sport = pick(65536);
        dport = pick(65536);
        csum  = pick(65536);
        plen  = 1 + pick(MAX_PAYLOAD);
        ulen  = `UDP_HDR_BYTES + plen;
        // 0 exact, 1 padded, 2 short payload, 3 short header
        if (kind == 2 && plen < 2)
            kind = 0;
        case (kind)
            1: flen = ulen + 1 + pick(MAX_PAD);
            2: flen = `UDP_HDR_BYTES + 1 + pick(plen - 1);
            3: flen = 1 + pick(`UDP_HDR_BYTES);
            default: flen = ulen;
        endcase
        bytes = '{sport[15:8], sport[7:0], dport[15:8], dport[7:0],
                  ulen[15:8], ulen[7:0], csum[15:8], csum[7:0]};
        while (bytes.size() > flen)
            void'(bytes.pop_back());
        while (bytes.size() < flen)
            bytes.push_back(pick(256));

        // expected results
        if (flen <= `UDP_HDR_BYTES) begin
            hdr_err_exp++;
        end else begin
            hdr_q.push_back({proto, src, dst, sport, dport, ulen, csum});
            nout = ((flen < ulen) ? flen : ulen) - `UDP_HDR_BYTES;
            for (int i = 0; i < nout; i++) begin
                pay_q.push_back({(flen < ulen) && (i == nout - 1), i == nout - 1,
                                 bytes[`UDP_HDR_BYTES + i]});
            end
            if (flen < ulen)
                pay_err_exp++;
        end

        // ip header
        s_ip_hdr_valid <= 1'b1;
        s_ip_protocol  <= proto;
        s_ip_source_ip <= src;
        s_ip_dest_ip   <= dst;
        do @(posedge clk); while (!s_ip_hdr_ready);
        s_ip_hdr_valid <= 1'b0;

        // payload with random gaps
        for (int i = 0; i < flen; i++) begin
            if (pick(4) == 0) begin
                s_ip_payload_tvalid <= 1'b0;
                @(posedge clk);
            end
            s_ip_payload_tvalid <= 1'b1;
            s_ip_payload_tdata  <= bytes[i];
            s_ip_payload_tlast  <= (i == flen - 1);
            do @(posedge clk); while (!s_ip_payload_tready);
        end
        s_ip_payload_tvalid <= 1'b0;
        s_ip_payload_tlast  <= 1'b0;
    endtask

    // compare every output transfer with the queue heads
    always @(posedge clk) begin
        logic [135:0] hexp;
        logic [9:0]   pexp;
        if (!rst) begin
            if (m_udp_payload_tvalid && m_udp_payload_tready) begin
                if (pay_q.size() == 0) begin
                    report($sformatf("unexpected payload byte %h", m_udp_payload_tdata));
                end else begin
                    pexp = pay_q.pop_front();
                    assert ({m_udp_payload_tuser, m_udp_payload_tlast,
                             m_udp_payload_tdata} == pexp)
                    else report($sformatf("payload got u%b l%b %h, expected u%b l%b %h",
                                m_udp_payload_tuser, m_udp_payload_tlast,
                                m_udp_payload_tdata, pexp[9], pexp[8], pexp[7:0]));
                end
            end
            if (m_udp_hdr_valid && m_udp_hdr_ready) begin
                if (hdr_q.size() == 0) begin
                    report("unexpected udp header");
                end else begin
                    hexp = hdr_q.pop_front();
                    assert ({m_ip_protocol, m_ip_source_ip, m_ip_dest_ip,
                             m_udp_source_port, m_udp_dest_port,
                             m_udp_length, m_udp_checksum} == hexp)
                    else report($sformatf("header mismatch, expected %h", hexp));
                end
            end
            if (error_header_early_termination)
                hdr_err_seen++;
            if (error_payload_early_termination)
                pay_err_seen++;
        end
    end

    a_pay_hold: assert property (
        @(posedge clk) disable iff (rst)
        m_udp_payload_tvalid && !m_udp_payload_tready |=>
            m_udp_payload_tvalid && $stable(m_udp_payload_tdata) &&
            $stable(m_udp_payload_tlast) && $stable(m_udp_payload_tuser)
    ) else report("payload valid dropped or data changed before transfer");

    a_hdr_hold: assert property (
        @(posedge clk) disable iff (rst)
        m_udp_hdr_valid && !m_udp_hdr_ready |=> m_udp_hdr_valid
    ) else report("header valid dropped before transfer");

    a_err_pulse: assert property (
        @(posedge clk) disable iff (rst)
        error_header_early_termination || error_payload_early_termination |=>
            !error_header_early_termination && !error_payload_early_termination
    ) else report("error output longer than one cycle");

    initial begin
        repeat (N_FRAMES * MAX_FRAME * 20) @(posedge clk);
        $display("timeout: frames did not drain within the cycle budget");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        s_ip_hdr_valid = 1'b0;
        s_ip_protocol = '0;
        s_ip_source_ip = '0;
        s_ip_dest_ip = '0;
        s_ip_payload_tdata = '0;
        s_ip_payload_tvalid = 1'b0;
        s_ip_payload_tlast = 1'b0;
        s_ip_payload_tuser = 1'b0;
        m_udp_hdr_ready = 1'b0;
        m_udp_payload_tready = 1'b0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        for (int f = 0; f < N_FRAMES; f++)
            send_frame(pick(4));
        while (pay_q.size() != 0 || hdr_q.size() != 0)
            @(posedge clk);
        repeat (10) @(posedge clk);
        assert (hdr_err_seen == hdr_err_exp)
        else report($sformatf("header errors %0d, expected %0d", hdr_err_seen, hdr_err_exp));
        assert (pay_err_seen == pay_err_exp)
        else report($sformatf("payload errors %0d, expected %0d",
                              pay_err_seen, pay_err_exp));
        $display("frames %0d, errors %0d", N_FRAMES, error_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+source
source/udp_rx_pkg.sv
source/udp_hdr_regs.sv
source/udp_rx_fsm.sv
source/axis_skid_buf.sv
source/udp_rx_top.sv
bench/udp_rx_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the udp receive stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module udp_rx_tb -o udp_rx_sim \
    && ./obj_dir/udp_rx_sim | tee /dev/stderr | grep -q "Simulation completed successfully" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
